// File: hdl/csrng_lite_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the command-driven random bit generator.
// Holds the command codes, the main FSM state set, header field
// positions, FIFO depths and the constants of the mixing step.
// ~~~~~~~~~~~~~~~~~~~~

package csrng_lite_pkg;

  // Data path widths.
  localparam int CmdWidth = 32;
  localparam int GenWidth = 32;
  localparam int MainSmStateWidth = 4;

  // Header word fields.
  localparam int CodeLsb = 0;
  localparam int CodeWidth = 3;
  localparam int Flag0Bit = 3;
  localparam int ClenLsb = 4;
  localparam int ClenWidth = 2;
  localparam int GlenLsb = 8;
  localparam int GlenWidth = 4;

  // FIFO depths, which are also the initial credit counts.
  localparam int AcmdDepth = 4;
  localparam int GenDepth = 4;
  localparam int GenCntWidth = $clog2(GenDepth + 1);

  // Generate step: add a constant, then fold in a rotated copy.
  localparam logic [GenWidth-1:0] GenMix = 32'h9e37_79b9;
  localparam int MixRot = 7;

  typedef logic [CmdWidth-1:0] acmd_word_t;
  typedef logic [GenWidth-1:0] gen_word_t;

  // Codes 0, 6 and 7 are illegal.
  typedef enum logic [CodeWidth-1:0] {
    INS = 3'd1,
    RES = 3'd2,
    GEN = 3'd3,
    UPD = 3'd4,
    UNI = 3'd5
  } acmd_e;

  typedef enum logic [MainSmStateWidth-1:0] {
    MainSmIdle          = 4'd0,
    MainSmParseCmd      = 4'd1,
    MainSmInstantPrep   = 4'd2,
    MainSmInstantReq    = 4'd3,
    MainSmReseedPrep    = 4'd4,
    MainSmReseedReq     = 4'd5,
    MainSmGeneratePrep  = 4'd6,
    MainSmGenerateReq   = 4'd7,
    MainSmUpdatePrep    = 4'd8,
    MainSmUpdateReq     = 4'd9,
    MainSmUninstantPrep = 4'd10,
    MainSmUninstantReq  = 4'd11,
    MainSmClrAData      = 4'd12,
    MainSmCmdCompWait   = 4'd13,
    MainSmError         = 4'd14
  } main_sm_state_e;

endpackage

// File: hdl/credit_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// Circular-buffer FIFO with a fill count and a first-word-fall-through
// read port. The payload type is a parameter, so the command path and
// the generated-bits path share this block.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module credit_fifo #(
  parameter type T = logic [31:0],
  parameter int DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o,
  output logic full_o
);

  T mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic do_push;
  logic do_pop;

  // Writes to a full FIFO and reads from an empty one are dropped.
  assign do_push = push_i && !full_o;
  assign do_pop = pop_i && !empty_o;
  assign empty_o = (count_q == '0);
  assign full_o = (count_q == ($clog2(DEPTH+1))'(DEPTH));
  assign data_o = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// File: hdl/acmd_intake.sv
// ~~~~~~~~~~~~~~~~~~~~
// Command intake. Buffers host words, returns one credit per pop,
// splits the header into fields and XOR-folds the additional data.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module acmd_intake import csrng_lite_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 acmd_valid_i,
  input  acmd_word_t           acmd_i,
  output logic                 acmd_credit_o,
  output logic                 acmd_avail_o,
  input  logic                 acmd_accept_i,
  output acmd_e                acmd_code_o,
  output logic                 flag0_o,
  output logic [GlenWidth-1:0] glen_o,
  output logic                 acmd_eop_o,
  output acmd_word_t           adata_o,
  input  logic                 clr_adata_i
);

  acmd_word_t fifo_data;
  logic fifo_pop;
  logic fifo_empty;
  logic fifo_full;
  logic fold_pop;
  logic self_clr;
  logic busy_q;
  logic eop_q;
  logic drop_q;
  logic credit_q;
  logic [ClenWidth-1:0] clen_q;
  acmd_word_t adata_q;
  acmd_e code_q;
  logic flag0_q;
  logic [GlenWidth-1:0] glen_q;

  credit_fifo #(
    .T     (acmd_word_t),
    .DEPTH (AcmdDepth)
  ) u_acmd_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (acmd_valid_i && !fifo_full),
    .data_i  (acmd_i),
    .pop_i   (fifo_pop),
    .data_o  (fifo_data),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  // A new header is offered only once the previous command is cleared.
  assign acmd_avail_o = !busy_q && !fifo_empty;
  assign fold_pop = busy_q && (clen_q != '0) && !fifo_empty;
  assign fifo_pop = acmd_accept_i || fold_pop;

  // Illegal commands and commands aborted mid-fold drop their own adata.
  assign self_clr = eop_q && (drop_q || !(code_q inside {INS, RES, GEN, UPD, UNI}));

  assign acmd_credit_o = credit_q;
  assign acmd_code_o = code_q;
  assign flag0_o = flag0_q;
  assign glen_o = glen_q;
  assign acmd_eop_o = eop_q;
  assign adata_o = adata_q;

  always_ff @(posedge clk_i) begin
    if (acmd_accept_i) begin
      code_q <= acmd_e'(fifo_data[CodeLsb +: CodeWidth]);
      flag0_q <= fifo_data[Flag0Bit];
      glen_q <= fifo_data[GlenLsb +: GlenWidth];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      eop_q <= 1'b0;
      drop_q <= 1'b0;
      credit_q <= 1'b0;
      clen_q <= '0;
      adata_q <= '0;
    end else begin
      credit_q <= fifo_pop;
      if (clr_adata_i && busy_q && !eop_q) begin
        drop_q <= 1'b1;
      end
      if (acmd_accept_i) begin
        busy_q <= 1'b1;
        clen_q <= fifo_data[ClenLsb +: ClenWidth];
        eop_q <= (fifo_data[ClenLsb +: ClenWidth] == '0);
      end else if (fold_pop) begin
        adata_q <= adata_q ^ fifo_data;
        clen_q <= clen_q - 1'b1;
        if (clen_q == ClenWidth'(1)) begin
          eop_q <= 1'b1;
        end
      end else if (self_clr || (clr_adata_i && eop_q)) begin
        busy_q <= 1'b0;
        eop_q <= 1'b0;
        drop_q <= 1'b0;
        adata_q <= '0;
      end
    end
  end

endmodule

// File: hdl/main_sm.sv
// ~~~~~~~~~~~~~~~~~~~~
// Command FSM. Accepts a header, waits for the adata fold, fetches
// entropy when needed, issues one core request and waits for it.
// Error has priority over escalation, escalation over disable.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module main_sm import csrng_lite_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        enable_i,
  input  logic                        acmd_avail_i,
  output logic                        acmd_accept_o,
  input  acmd_e                       acmd_i,
  input  logic                        acmd_eop_i,
  input  logic                        core_rdy_i,
  input  logic                        flag0_i,
  output logic                        cmd_entropy_req_o,
  input  logic                        cmd_entropy_avail_i,
  output logic                        instant_req_o,
  output logic                        reseed_req_o,
  output logic                        generate_req_o,
  output logic                        update_req_o,
  output logic                        uninstant_req_o,
  output logic                        clr_adata_o,
  input  logic                        cmd_complete_i,
  input  logic                        escalate_i,
  output logic [MainSmStateWidth-1:0] main_sm_state_o,
  output logic                        main_sm_alert_o,
  output logic                        main_sm_err_o
);

  main_sm_state_e state_d;
  main_sm_state_e state_q;

  assign main_sm_state_o = state_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= MainSmIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    acmd_accept_o = 1'b0;
    cmd_entropy_req_o = 1'b0;
    instant_req_o = 1'b0;
    reseed_req_o = 1'b0;
    generate_req_o = 1'b0;
    update_req_o = 1'b0;
    uninstant_req_o = 1'b0;
    clr_adata_o = 1'b0;
    main_sm_alert_o = 1'b0;
    main_sm_err_o = 1'b0;

    if (state_q == MainSmError) begin
      // Sticky until reset.
      main_sm_err_o = 1'b1;
    end else if (escalate_i) begin
      state_d = MainSmError;
    end else if (!enable_i && state_q inside {[MainSmIdle:MainSmCmdCompWait]}) begin
      state_d = MainSmIdle;
      // Leaving mid-command also releases the intake.
      clr_adata_o = (state_q != MainSmIdle);
    end else begin
      case (state_q)
        MainSmIdle: begin
          if (core_rdy_i && acmd_avail_i) begin
            acmd_accept_o = 1'b1;
            state_d = MainSmParseCmd;
          end
        end
        MainSmParseCmd: begin
          if (!(acmd_i inside {INS, RES, GEN, UPD, UNI})) begin
            main_sm_alert_o = 1'b1;
            state_d = MainSmIdle;
          end else if (core_rdy_i && acmd_eop_i) begin
            case (acmd_i)
              INS: state_d = MainSmInstantPrep;
              RES: state_d = MainSmReseedPrep;
              GEN: state_d = MainSmGeneratePrep;
              UPD: state_d = MainSmUpdatePrep;
              default: state_d = MainSmUninstantPrep;
            endcase
          end
        end
        MainSmInstantPrep: begin
          // Entropy is skipped when flag0 is set.
          cmd_entropy_req_o = !flag0_i;
          if (flag0_i || cmd_entropy_avail_i) begin
            state_d = MainSmInstantReq;
          end
        end
        MainSmInstantReq: begin
          instant_req_o = 1'b1;
          state_d = MainSmClrAData;
        end
        MainSmReseedPrep: begin
          cmd_entropy_req_o = !flag0_i;
          if (flag0_i || cmd_entropy_avail_i) begin
            state_d = MainSmReseedReq;
          end
        end
        MainSmReseedReq: begin
          reseed_req_o = 1'b1;
          state_d = MainSmClrAData;
        end
        MainSmGeneratePrep: state_d = MainSmGenerateReq;
        MainSmGenerateReq: begin
          generate_req_o = 1'b1;
          state_d = MainSmClrAData;
        end
        MainSmUpdatePrep: state_d = MainSmUpdateReq;
        MainSmUpdateReq: begin
          update_req_o = 1'b1;
          state_d = MainSmClrAData;
        end
        MainSmUninstantPrep: state_d = MainSmUninstantReq;
        MainSmUninstantReq: begin
          uninstant_req_o = 1'b1;
          state_d = MainSmClrAData;
        end
        MainSmClrAData: begin
          clr_adata_o = 1'b1;
          // Non-generate commands complete while the adata is cleared.
          if (cmd_complete_i) begin
            state_d = MainSmIdle;
          end else begin
            state_d = MainSmCmdCompWait;
          end
        end
        MainSmCmdCompWait: begin
          if (cmd_complete_i) begin
            state_d = MainSmIdle;
          end
        end
        // Any unknown encoding is treated as a fault.
        default: begin
          state_d = MainSmError;
          main_sm_err_o = 1'b1;
        end
      endcase
    end
  end

endmodule

// File: hdl/drbg_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// Simplified deterministic core. Keeps one working value and applies
// the five commands to it; generate streams glen mixed words.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module drbg_core import csrng_lite_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 instant_req_i,
  input  logic                 reseed_req_i,
  input  logic                 generate_req_i,
  input  logic                 update_req_i,
  input  logic                 uninstant_req_i,
  input  logic                 entropy_ack_i,
  input  gen_word_t            entropy_i,
  input  logic                 flag0_i,
  input  acmd_word_t           adata_i,
  input  logic [GlenWidth-1:0] glen_i,
  output logic                 core_rdy_o,
  output logic                 cmd_complete_o,
  output logic                 cmd_sts_o,
  output logic                 gen_push_o,
  output gen_word_t            gen_word_o,
  input  logic                 gen_full_i
);

  gen_word_t v_q;
  gen_word_t ent_q;
  gen_word_t ent_sel;
  gen_word_t v_step;
  logic inst_q;
  logic gen_busy_q;
  logic complete_q;
  logic sts_q;
  logic [GlenWidth-1:0] gen_cnt_q;

  assign ent_sel = flag0_i ? '0 : ent_q;
  assign v_step = v_q + GenMix;
  assign gen_word_o = v_step ^ ((v_step << MixRot) | (v_step >> (GenWidth - MixRot)));

  // One word per cycle, stalled by a full output FIFO.
  assign gen_push_o = gen_busy_q && !gen_full_i;
  assign core_rdy_o = !gen_busy_q && !complete_q;
  assign cmd_complete_o = complete_q;
  assign cmd_sts_o = complete_q && sts_q;

  always_ff @(posedge clk_i) begin
    if (entropy_ack_i) begin
      ent_q <= entropy_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      v_q <= '0;
      inst_q <= 1'b0;
      gen_busy_q <= 1'b0;
      complete_q <= 1'b0;
      sts_q <= 1'b0;
      gen_cnt_q <= '0;
    end else begin
      complete_q <= 1'b0;
      if (instant_req_i) begin
        v_q <= ent_sel ^ adata_i;
        inst_q <= 1'b1;
        sts_q <= 1'b0;
        complete_q <= 1'b1;
      end else if (reseed_req_i) begin
        if (inst_q) begin
          v_q <= v_q ^ ent_sel ^ adata_i;
        end
        sts_q <= !inst_q;
        complete_q <= 1'b1;
      end else if (update_req_i) begin
        if (inst_q) begin
          v_q <= v_q ^ adata_i;
        end
        sts_q <= !inst_q;
        complete_q <= 1'b1;
      end else if (uninstant_req_i) begin
        v_q <= '0;
        inst_q <= 1'b0;
        sts_q <= 1'b0;
        complete_q <= 1'b1;
      end else if (generate_req_i) begin
        sts_q <= !inst_q;
        if (inst_q && glen_i != '0) begin
          gen_busy_q <= 1'b1;
          gen_cnt_q <= glen_i;
        end else begin
          complete_q <= 1'b1;
        end
      end else if (gen_push_o) begin
        v_q <= v_step;
        gen_cnt_q <= gen_cnt_q - 1'b1;
        // Completion follows the last push by one cycle.
        if (gen_cnt_q == GlenWidth'(1)) begin
          gen_busy_q <= 1'b0;
          complete_q <= 1'b1;
        end
      end
    end
  end

endmodule

// File: hdl/genbits_out.sv
// ~~~~~~~~~~~~~~~~~~~~
// Output side. Buffers generated words and streams one per cycle to
// the consumer while it holds credit.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module genbits_out import csrng_lite_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      gen_push_i,
  input  gen_word_t gen_word_i,
  output logic      gen_full_o,
  output logic      genbits_valid_o,
  output gen_word_t genbits_o,
  input  logic      genbits_credit_i
);

  gen_word_t fifo_data;
  gen_word_t word_q;
  logic fifo_pop;
  logic fifo_empty;
  logic valid_q;
  logic [GenCntWidth-1:0] credit_q;

  credit_fifo #(
    .T     (gen_word_t),
    .DEPTH (GenDepth)
  ) u_gen_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (gen_push_i),
    .data_i  (gen_word_i),
    .pop_i   (fifo_pop),
    .data_o  (fifo_data),
    .empty_o (fifo_empty),
    .full_o  (gen_full_o)
  );

  assign fifo_pop = !fifo_empty && (credit_q != '0);
  assign genbits_valid_o = valid_q;
  assign genbits_o = word_q;

  always_ff @(posedge clk_i) begin
    if (fifo_pop) begin
      word_q <= fifo_data;
    end
  end

  // Consumer starts with one credit per FIFO entry.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      credit_q <= GenCntWidth'(GenDepth);
    end else begin
      valid_q <= fifo_pop;
      credit_q <= credit_q + GenCntWidth'(genbits_credit_i) - GenCntWidth'(fifo_pop);
    end
  end

endmodule

// File: hdl/csrng_lite_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Top level of the random bit generator. Connects the command intake,
// the command FSM, the core and the output side.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module csrng_lite_top import csrng_lite_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       enable_i,
  input  logic       acmd_valid_i,
  input  acmd_word_t acmd_i,
  output logic       acmd_credit_o,
  output logic       entropy_req_o,
  input  logic       entropy_ack_i,
  input  gen_word_t  entropy_i,
  input  logic       escalate_i,
  output logic       genbits_valid_o,
  output gen_word_t  genbits_o,
  input  logic       genbits_credit_i,
  output logic       cmd_ack_o,
  output logic       cmd_sts_o,
  output logic       alert_o,
  output logic       err_o
);

  acmd_e acmd_code;
  acmd_word_t adata;
  gen_word_t gen_word;
  logic [GlenWidth-1:0] glen;
  logic acmd_avail;
  logic acmd_accept;
  logic acmd_eop;
  logic flag0;
  logic clr_adata;
  logic core_rdy;
  logic instant_req;
  logic reseed_req;
  logic generate_req;
  logic update_req;
  logic uninstant_req;
  logic cmd_complete;
  logic gen_push;
  logic gen_full;

  assign cmd_ack_o = cmd_complete;

  acmd_intake u_acmd_intake (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .acmd_valid_i  (acmd_valid_i),
    .acmd_i        (acmd_i),
    .acmd_credit_o (acmd_credit_o),
    .acmd_avail_o  (acmd_avail),
    .acmd_accept_i (acmd_accept),
    .acmd_code_o   (acmd_code),
    .flag0_o       (flag0),
    .glen_o        (glen),
    .acmd_eop_o    (acmd_eop),
    .adata_o       (adata),
    .clr_adata_i   (clr_adata)
  );

  main_sm u_main_sm (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .enable_i            (enable_i),
    .acmd_avail_i        (acmd_avail),
    .acmd_accept_o       (acmd_accept),
    .acmd_i              (acmd_code),
    .acmd_eop_i          (acmd_eop),
    .core_rdy_i          (core_rdy),
    .flag0_i             (flag0),
    .cmd_entropy_req_o   (entropy_req_o),
    .cmd_entropy_avail_i (entropy_ack_i),
    .instant_req_o       (instant_req),
    .reseed_req_o        (reseed_req),
    .generate_req_o      (generate_req),
    .update_req_o        (update_req),
    .uninstant_req_o     (uninstant_req),
    .clr_adata_o         (clr_adata),
    .cmd_complete_i      (cmd_complete),
    .escalate_i          (escalate_i),
    .main_sm_state_o     (),
    .main_sm_alert_o     (alert_o),
    .main_sm_err_o       (err_o)
  );

  drbg_core u_drbg_core (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .instant_req_i   (instant_req),
    .reseed_req_i    (reseed_req),
    .generate_req_i  (generate_req),
    .update_req_i    (update_req),
    .uninstant_req_i (uninstant_req),
    .entropy_ack_i   (entropy_ack_i),
    .entropy_i       (entropy_i),
    .flag0_i         (flag0),
    .adata_i         (adata),
    .glen_i          (glen),
    .core_rdy_o      (core_rdy),
    .cmd_complete_o  (cmd_complete),
    .cmd_sts_o       (cmd_sts_o),
    .gen_push_o      (gen_push),
    .gen_word_o      (gen_word),
    .gen_full_i      (gen_full)
  );

  genbits_out u_genbits_out (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .gen_push_i       (gen_push),
    .gen_word_i       (gen_word),
    .gen_full_o       (gen_full),
    .genbits_valid_o  (genbits_valid_o),
    .genbits_o        (genbits_o),
    .genbits_credit_i (genbits_credit_i)
  );

endmodule

// File: verif/csrng_lite_props.sv
// ~~~~~~~~~~~~~~~~~~~~
// Protocol and error-state properties of the generator top level.
// Bound to csrng_lite_top; fail_cnt counts failed properties.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module csrng_lite_props import csrng_lite_pkg::*; (
  input logic clk_i,
  input logic rst_n_i,
  input logic enable_i,
  input logic escalate_i,
  input logic acmd_valid_i,
  input logic acmd_credit_o,
  input logic entropy_req_o,
  input logic entropy_ack_i,
  input logic genbits_valid_o,
  input logic genbits_credit_i,
  input logic err_o
);

  int host_credits_q;
  int gen_credits_q;
  int fail_cnt = 0;

  // Credit counters as seen from both ends of each link.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      host_credits_q <= AcmdDepth;
      gen_credits_q <= GenDepth;
    end else begin
      host_credits_q <= host_credits_q - int'(acmd_valid_i) + int'(acmd_credit_o);
      gen_credits_q <= gen_credits_q - int'(genbits_valid_o) + int'(genbits_credit_i);
    end
  end

  a_host_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acmd_valid_i |-> host_credits_q > 0)
    else begin $error("command word sent without credit"); fail_cnt++; end

  a_gen_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    genbits_valid_o |-> gen_credits_q > 0)
    else begin $error("generated word sent without credit"); fail_cnt++; end

  a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    err_o |=> err_o)
    else begin $error("err_o dropped before reset"); fail_cnt++; end

  // A request is only withdrawn by disable or escalation.
  a_req_hold: assert property (@(posedge clk_i)
    disable iff (!rst_n_i || !enable_i || escalate_i)
    entropy_req_o && !entropy_ack_i |=> entropy_req_o)
    else begin $error("entropy_req_o dropped before ack"); fail_cnt++; end

endmodule

// File: verif/tb_csrng_lite.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the random bit generator. Drives host commands, answers
// entropy requests, returns consumer credits and checks against a model.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_csrng_lite import csrng_lite_pkg::*; ();

  logic clk = 0;
  logic rst_n = 0;
  logic enable = 0;
  logic acmd_valid = 0;
  logic ent_ack = 0;
  logic escalate = 0;
  logic gen_credit = 0;
  logic [31:0] acmd = '0;
  logic [31:0] entropy = '0;
  logic [31:0] last_ent = '0;
  logic [31:0] model_v = '0;
  wire acmd_credit;
  wire ent_req;
  wire gen_valid;
  wire cmd_ack;
  wire cmd_sts;
  wire alert;
  wire err;
  wire [31:0] genbits;
  int seed = 32'h369a;
  int sent = 0;
  int returned = 0;
  int owed = 0;
  int ack_cnt = 0;
  int alert_cnt = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_err = 0;
  bit hold = 0;
  bit mute = 0;
  bit req_seen = 0;
  bit last_sts = 0;
  logic [31:0] rx_q[$];

  csrng_lite_top UUT (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .enable_i         (enable),
    .acmd_valid_i     (acmd_valid),
    .acmd_i           (acmd),
    .acmd_credit_o    (acmd_credit),
    .entropy_req_o    (ent_req),
    .entropy_ack_i    (ent_ack),
    .entropy_i        (entropy),
    .escalate_i       (escalate),
    .genbits_valid_o  (gen_valid),
    .genbits_o        (genbits),
    .genbits_credit_i (gen_credit),
    .cmd_ack_o        (cmd_ack),
    .cmd_sts_o        (cmd_sts),
    .alert_o          (alert),
    .err_o            (err)
  );

  bind csrng_lite_top csrng_lite_props u_props (.*);

  always #4 clk = ~clk;

  // Outputs are sampled at the falling edge, away from register updates.
  always @(negedge clk) begin
    if (acmd_credit) returned++;
    if (ent_req) req_seen = 1;
    if (alert) alert_cnt++;
    if (cmd_ack) begin
      ack_cnt++;
      last_sts = cmd_sts;
    end
    if (gen_valid) begin
      rx_q.push_back(genbits);
      owed++;
    end
  end

  // Consumer returns one credit per received word unless held.
  always @(posedge clk) begin
    #1;
    gen_credit = 0;
    if (!hold && owed > 0) begin
      gen_credit = 1;
      owed--;
    end
  end

  // Entropy source answers after a random delay with a random word.
  initial begin
    int delay;
    forever begin
      @(negedge clk);
      if (ent_req && !mute) begin
        delay = $random(seed) & 7;
        repeat (delay) @(negedge clk);
        if (ent_req && !mute) begin
          @(posedge clk);
          #1;
          ent_ack = 1;
          entropy = $random(seed);
          last_ent = entropy;
          @(posedge clk);
          #1;
          ent_ack = 0;
        end
      end
    end
  end

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s at %0t", what, $time);
    $display("Test failed");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic apply_reset();
    rst_n = 0;
    repeat (16) @(posedge clk);
    #1;
    sent = 0;
    returned = 0;
    owed = 0;
    model_v = '0;
    rx_q.delete();
    rst_n = 1;
  endtask

  task automatic push_word(input logic [31:0] w);
    int t;
    t = 0;
    while (AcmdDepth - sent + returned <= 0) begin
      @(posedge clk);
      #1;
      if (++t > 2000) abort_on_timeout("a host credit");
    end
    acmd_valid = 1;
    acmd = w;
    sent++;
    @(posedge clk);
    #1;
    acmd_valid = 0;
  endtask

  // Sends a header and n adata words; returns the XOR fold of the adata.
  task automatic send_cmd(input int code, input bit f0, input int glen, input int n,
                          input logic [31:0] ad[3], output logic [31:0] fold);
    fold = '0;
    push_word(32'(code) | (32'(f0) << 3) | (32'(n) << 4) | (32'(glen) << 8));
    for (int i = 0; i < n; i++) begin
      push_word(ad[i]);
      fold = fold ^ ad[i];
    end
  endtask

  task automatic wait_ack(input bit exp_sts);
    int t, start;
    t = 0;
    start = ack_cnt;
    while (ack_cnt == start) begin
      @(posedge clk);
      #1;
      if (++t > 2000) abort_on_timeout("cmd_ack_o");
    end
    check_value("cmd_sts_o", 32'(last_sts), 32'(exp_sts));
  endtask

  // Runs the generate rule on the model and compares n received words.
  task automatic check_words(input int n);
    int t;
    t = 0;
    while (rx_q.size() < n) begin
      @(posedge clk);
      #1;
      if (++t > 2000) abort_on_timeout("generated words");
    end
    for (int i = 0; i < n; i++) begin
      model_v = model_v + GenMix;
      check_value("genbits_o", rx_q.pop_front(),
                  model_v ^ {model_v[31-MixRot:0], model_v[31:32-MixRot]});
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s: %s", tests, name, (errors == test_err) ? "ok" : "errors");
    test_err = errors;
  endtask

  initial begin
    logic [31:0] a;
    int t;
    int acks;
    apply_reset();
    enable = 1;

    send_cmd(INS, 0, 0, 2, '{32'h1234_5678, 32'h0f0f_00ff, 0}, a);
    wait_ack(0);
    model_v = last_ent ^ a;
    send_cmd(GEN, 0, 4, 0, '{0, 0, 0}, a);
    wait_ack(0);
    check_words(4);
    t = 0;
    while (returned != sent) begin
      @(posedge clk);
      #1;
      if (++t > 200) abort_on_timeout("host credits to return");
    end
    end_test("instantiate and generate");

    req_seen = 0;
    send_cmd(INS, 1, 0, 1, '{32'hcafe_0001, 0, 0}, a);
    wait_ack(0);
    check_value("entropy_req_o seen", 32'(req_seen), 0);
    model_v = a;
    send_cmd(UPD, 0, 0, 3, '{32'h5555_aaaa, 32'h0000_1111, 32'h8000_0001}, a);
    wait_ack(0);
    model_v = model_v ^ a;
    send_cmd(RES, 0, 0, 1, '{32'h7777_0000, 0, 0}, a);
    wait_ack(0);
    model_v = model_v ^ last_ent ^ a;
    send_cmd(GEN, 0, 3, 0, '{0, 0, 0}, a);
    wait_ack(0);
    check_words(3);
    end_test("flag0, update and reseed");

    hold = 1;
    acks = ack_cnt;
    send_cmd(GEN, 0, 12, 0, '{0, 0, 0}, a);
    repeat (40) @(posedge clk);
    #1;
    check_value("words under back-pressure", 32'(rx_q.size() <= GenDepth), 1);
    check_value("ack under back-pressure", ack_cnt, acks);
    hold = 0;
    wait_ack(0);
    check_words(12);
    end_test("back-pressure");

    acks = ack_cnt;
    send_cmd(0, 0, 0, 1, '{32'hdead_beef, 0, 0}, a);
    t = 0;
    while (alert_cnt == 0) begin
      @(posedge clk);
      #1;
      if (++t > 2000) abort_on_timeout("alert_o");
    end
    repeat (10) @(posedge clk);
    #1;
    check_value("alert count", alert_cnt, 1);
    check_value("ack after illegal code", ack_cnt, acks);
    send_cmd(UPD, 0, 0, 1, '{32'h0123_4567, 0, 0}, a);
    wait_ack(0);
    model_v = model_v ^ a;
    send_cmd(UNI, 0, 0, 0, '{0, 0, 0}, a);
    wait_ack(0);
    model_v = '0;
    send_cmd(GEN, 0, 2, 0, '{0, 0, 0}, a);
    wait_ack(1);
    repeat (10) @(posedge clk);
    #1;
    check_value("words while uninstantiated", rx_q.size(), 0);
    end_test("illegal code and uninstantiate");

    mute = 1;
    send_cmd(INS, 0, 0, 0, '{0, 0, 0}, a);
    t = 0;
    while (!ent_req) begin
      @(posedge clk);
      #1;
      if (++t > 2000) abort_on_timeout("entropy_req_o");
    end
    enable = 0;
    repeat (3) @(posedge clk);
    #1;
    check_value("entropy_req_o while disabled", 32'(ent_req), 0);
    enable = 1;
    mute = 0;
    send_cmd(INS, 0, 0, 1, '{32'h2468_ace0, 0, 0}, a);
    wait_ack(0);
    model_v = last_ent ^ a;
    send_cmd(GEN, 0, 1, 0, '{0, 0, 0}, a);
    wait_ack(0);
    check_words(1);
    end_test("disable during entropy wait");

    escalate = 1;
    @(posedge clk);
    #1;
    escalate = 0;
    acks = ack_cnt;
    send_cmd(GEN, 0, 1, 0, '{0, 0, 0}, a);
    repeat (30) @(posedge clk);
    #1;
    check_value("err_o after escalation", 32'(err), 1);
    check_value("ack in error state", ack_cnt, acks);
    apply_reset();
    send_cmd(INS, 1, 0, 1, '{32'h1357_9bdf, 0, 0}, a);
    wait_ack(0);
    model_v = a;
    send_cmd(GEN, 0, 2, 0, '{0, 0, 0}, a);
    wait_ack(0);
    check_words(2);
    end_test("escalation and reset");

    errors = errors + UUT.u_props.fail_cnt;
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sources.f
hdl/csrng_lite_pkg.sv
hdl/credit_fifo.sv
hdl/acmd_intake.sv
hdl/main_sm.sv
hdl/drbg_core.sv
hdl/genbits_out.sv
hdl/csrng_lite_top.sv
verif/csrng_lite_props.sv
verif/tb_csrng_lite.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_csrng_lite
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
